// ==== hw/mvu_pkg.sv ====
package mvu_pkg;

    // Plane and bank geometry
    localparam int N_LANES      = 16;   // Vector elements, one bit each per plane
    localparam int BBANKA       = 6;    // Bank address width, 64 planes per bank

    // Job configuration fields
    localparam int BPREC        = 2;    // Precision minus one, so 1 to 4 bits
    localparam int BSHIFT       = 3;    // Pair significance, weight bit plus input bit

    // Datapath widths
    localparam int BPOP         = 5;    // Popcount of a 16-bit plane, 0 to 16
    localparam int BACC         = 16;   // Holds 16 x 15 x 15 without wrap

    // Quantizer
    localparam int BQMSBIDX     = 4;    // MSB index into the accumulator
    localparam int BQOUT        = 4;    // Widest output precision

    // Read path from request register to operand output
    localparam int MEMRDLATENCY = 2;

endpackage

// ==== hw/mvu_agu.sv ====
`timescale 1ns/100ps

module mvu_agu (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,       // Job request from host
    input  logic                        done,        // End of job from VVP
    input  logic [mvu_pkg::BBANKA-1:0]  wbaseaddr,   // Weight plane of bit 0
    input  logic [mvu_pkg::BBANKA-1:0]  ibaseaddr,   // Input plane of bit 0
    input  logic [mvu_pkg::BBANKA-1:0]  wstride,     // Distance between weight planes
    input  logic [mvu_pkg::BBANKA-1:0]  istride,     // Distance between input planes
    input  logic [mvu_pkg::BPREC-1:0]   wprecision,  // Weight bits minus one
    input  logic [mvu_pkg::BPREC-1:0]   iprecision,  // Input bits minus one
    output logic                        job_start,   // Start accepted this edge
    output logic                        busy,        // Job in flight
    output logic                        rd_en,       // Plane pair request
    output logic                        rd_last,     // Final pair of the job
    output logic [mvu_pkg::BBANKA-1:0]  rd_waddr,
    output logic [mvu_pkg::BBANKA-1:0]  rd_iaddr,
    output logic [mvu_pkg::BSHIFT-1:0]  rd_shift     // Significance of the pair
);
    import mvu_pkg::*;

    logic              busy_q;      // Set on accept, dropped by done
    logic [BBANKA-1:0] wbase_q;
    logic [BBANKA-1:0] ibase_q;
    logic [BBANKA-1:0] wstride_q;
    logic [BBANKA-1:0] istride_q;
    logic [BPREC-1:0]  iprec_q;     // Reload value for the inner loop
    logic [BPREC-1:0]  wbit;        // Outer loop, weight bit, MSB first
    logic [BPREC-1:0]  ibit;        // Inner loop, input bit, MSB first
    logic [BBANKA-1:0] woff;
    logic [BBANKA-1:0] ioff;

    // Busy drops in the same cycle done is high, so the next start can land there
    assign busy      = busy_q & ~done;
    assign job_start = start & ~busy;

    // Job state and configuration buffer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else if (job_start) begin
            busy_q <= 1'b1;                     // Accept wins over a same-edge done
        end else if (done) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (job_start) begin                    // Config sampled only on accept
            wbase_q   <= wbaseaddr;
            ibase_q   <= ibaseaddr;
            wstride_q <= wstride;
            istride_q <= istride;
            iprec_q   <= iprecision;
        end
    end

    // Bit walk, one pair per cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_en <= 1'b0;
            wbit  <= '0;
            ibit  <= '0;
        end else if (job_start) begin
            rd_en <= 1'b1;                      // First pair in the cycle after accept
            wbit  <= wprecision;
            ibit  <= iprecision;
        end else if (rd_en) begin
            if (ibit != '0) begin
                ibit <= ibit - 1'b1;            // Next input bit
            end else if (wbit != '0) begin
                wbit <= wbit - 1'b1;            // Next weight bit, restart inputs
                ibit <= iprec_q;
            end else begin
                rd_en <= 1'b0;                  // Last pair issued
            end
        end
    end

    // Plane addresses, wrap inside the bank
    assign woff     = BBANKA'(wbit) * wstride_q;
    assign ioff     = BBANKA'(ibit) * istride_q;
    assign rd_waddr = wbase_q + woff;
    assign rd_iaddr = ibase_q + ioff;
    assign rd_shift = BSHIFT'(wbit) + BSHIFT'(ibit);
    assign rd_last  = rd_en && (wbit == '0) && (ibit == '0);

    // The walk lives strictly inside a job, done included
    a_rd_in_job: assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> busy)
        else $error("mvu_agu: rd_en high while not busy");

endmodule

// ==== hw/mvu_bank.sv ====
`timescale 1ns/100ps

module mvu_bank (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        busy,       // Blocks host data writes
    input  logic                        wrw_en,     // Weight write, no handshake
    input  logic [mvu_pkg::BBANKA-1:0]  wrw_addr,
    input  logic [mvu_pkg::N_LANES-1:0] wrw_word,
    input  logic                        wrc_en,     // Data write request
    input  logic [mvu_pkg::BBANKA-1:0]  wrc_addr,
    input  logic [mvu_pkg::N_LANES-1:0] wrc_word,
    input  logic                        rd_en,
    input  logic [mvu_pkg::BBANKA-1:0]  rd_waddr,
    input  logic [mvu_pkg::BBANKA-1:0]  rd_iaddr,
    input  logic [mvu_pkg::BSHIFT-1:0]  rd_shift,
    input  logic                        rd_last,
    output logic                        wrc_grnt,   // Data write accepted
    output logic                        op_valid,
    output logic [mvu_pkg::N_LANES-1:0] op_wplane,
    output logic [mvu_pkg::N_LANES-1:0] op_iplane,
    output logic [mvu_pkg::BSHIFT-1:0]  op_shift,
    output logic                        op_last
);
    import mvu_pkg::*;

    logic [N_LANES-1:0] mem_w [2**BBANKA];              // Weight bank
    logic [N_LANES-1:0] mem_d [2**BBANKA];              // Data bank
    logic [BBANKA-1:0]  waddr_q;                        // Request register
    logic [BBANKA-1:0]  iaddr_q;
    logic [N_LANES-1:0] wpipe [MEMRDLATENCY];           // Read data stages
    logic [N_LANES-1:0] ipipe [MEMRDLATENCY];
    logic [MEMRDLATENCY:0] valid_pipe;                  // Sideband, request stage included
    logic [MEMRDLATENCY:0] last_pipe;
    logic [BSHIFT-1:0]  shift_pipe [MEMRDLATENCY+1];

    // Host owns the data bank only while no job runs
    assign wrc_grnt = wrc_en & ~busy;

    // Write ports
    always_ff @(posedge clk) begin
        if (wrw_en) begin
            mem_w[wrw_addr] <= wrw_word;
        end
        if (wrc_en && wrc_grnt) begin
            mem_d[wrc_addr] <= wrc_word;
        end
    end

    // Read path, request register then MEMRDLATENCY data stages
    always_ff @(posedge clk) begin
        waddr_q  <= rd_waddr;
        iaddr_q  <= rd_iaddr;
        wpipe[0] <= mem_w[waddr_q];
        ipipe[0] <= mem_d[iaddr_q];
        for (int s = 1; s < MEMRDLATENCY; s++) begin
            wpipe[s] <= wpipe[s-1];
            ipipe[s] <= ipipe[s-1];
        end
    end

    // Sideband follows the data with the same depth
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_pipe <= '0;
            last_pipe  <= '0;
        end else begin
            valid_pipe <= {valid_pipe[MEMRDLATENCY-1:0], rd_en};
            last_pipe  <= {last_pipe[MEMRDLATENCY-1:0], rd_last};
        end
    end

    always_ff @(posedge clk) begin
        shift_pipe[0] <= rd_shift;
        for (int s = 1; s <= MEMRDLATENCY; s++) begin
            shift_pipe[s] <= shift_pipe[s-1];
        end
    end

    assign op_valid  = valid_pipe[MEMRDLATENCY];
    assign op_last   = last_pipe[MEMRDLATENCY];
    assign op_shift  = shift_pipe[MEMRDLATENCY];
    assign op_wplane = wpipe[MEMRDLATENCY-1];
    assign op_iplane = ipipe[MEMRDLATENCY-1];

    // A host write must never race a plane read of the running job
    a_no_wr_during_rd: assert property (@(posedge clk) disable iff (!rst_n)
        (wrc_en && wrc_grnt) |-> !rd_en)
        else $error("mvu_bank: data write granted during a read");

endmodule

// ==== hw/mvu_vvp.sv ====
`timescale 1ns/100ps

module mvu_vvp (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         job_start,     // Accepting edge of a job
    input  logic [mvu_pkg::BPREC-1:0]    oprecision,    // Output bits minus one
    input  logic [mvu_pkg::BQMSBIDX-1:0] quant_msbidx,  // Accumulator bit for result MSB
    input  logic                         op_valid,
    input  logic [mvu_pkg::N_LANES-1:0]  op_wplane,
    input  logic [mvu_pkg::N_LANES-1:0]  op_iplane,
    input  logic [mvu_pkg::BSHIFT-1:0]   op_shift,
    input  logic                         op_last,
    output logic                         done,          // One-cycle end of job
    output logic                         irq,           // Held until next start
    output logic [mvu_pkg::BQOUT-1:0]    result
);
    import mvu_pkg::*;

    logic [BPREC-1:0]    oprec_q;       // Latched on accept
    logic [BQMSBIDX-1:0] qmsb_q;
    logic                in_job_q;      // From accept to done
    logic [N_LANES-1:0]  andw;
    logic [BPOP-1:0]     pop;
    logic                pop_valid_q;   // Stage 1
    logic                pop_last_q;
    logic [BPOP-1:0]     pop_q;
    logic [BSHIFT-1:0]   pop_shift_q;
    logic [BACC-1:0]     acc_q;         // Stage 2
    logic                acc_done_q;
    logic [BQOUT-1:0]    qword;         // Quantizer output
    logic                ovf;

    always_ff @(posedge clk) begin
        if (job_start) begin
            oprec_q <= oprecision;
            qmsb_q  <= quant_msbidx;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_job_q <= 1'b0;
        end else if (job_start) begin
            in_job_q <= 1'b1;
        end else if (acc_done_q) begin
            in_job_q <= 1'b0;           // Drops with the done edge
        end
    end

    // Ones in the AND of the two planes
    assign andw = op_wplane & op_iplane;

    always_comb begin
        pop = '0;
        for (int l = 0; l < N_LANES; l++) begin
            pop = pop + BPOP'(andw[l]);
        end
    end

    // Stage 1, register the count with its sideband
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pop_valid_q <= 1'b0;
            pop_last_q  <= 1'b0;
        end else begin
            pop_valid_q <= op_valid & in_job_q;
            pop_last_q  <= op_valid & in_job_q & op_last;
        end
    end

    always_ff @(posedge clk) begin
        pop_q       <= pop;
        pop_shift_q <= op_shift;
    end

    // Stage 2, shift-accumulate by significance
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_q      <= '0;
            acc_done_q <= 1'b0;
        end else begin
            acc_done_q <= pop_last_q;
            if (job_start) begin
                acc_q <= '0;            // Fresh sum per job
            end else if (pop_valid_q) begin
                acc_q <= acc_q + (BACC'(pop_q) << pop_shift_q);
            end
        end
    end

    // Quantizer window, MSB at qmsb_q, oprec_q+1 bits wide
    always_comb begin
        int src;
        ovf   = 1'b0;
        qword = '0;
        for (int b = 0; b < BACC; b++) begin
            if (b > int'(qmsb_q) && acc_q[b]) begin
                ovf = 1'b1;             // Sum exceeds the window
            end
        end
        for (int j = 0; j < BQOUT; j++) begin
            src = int'(qmsb_q) - int'(oprec_q) + j;
            if (j <= int'(oprec_q) && src >= 0) begin
                qword[j] = acc_q[src];  // Below bit 0 stays zero
            end
        end
        if (ovf) begin
            for (int j = 0; j < BQOUT; j++) begin
                qword[j] = (j <= int'(oprec_q)); // Saturate within output width
            end
        end
    end

    // Result, done and irq
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;
            done   <= 1'b0;
            irq    <= 1'b0;
        end else begin
            done <= acc_done_q;
            if (acc_done_q) begin
                result <= qword;
            end
            if (job_start) begin
                irq <= 1'b0;            // Acknowledged by the next job
            end else if (acc_done_q) begin
                irq <= 1'b1;
            end
        end
    end

    // Bank output must belong to a job the AGU accepted
    a_op_in_job: assert property (@(posedge clk) disable iff (!rst_n) op_valid |-> in_job_q)
        else $error("mvu_vvp: operand valid outside a job");

endmodule

// ==== hw/mvu_top.sv ====
`timescale 1ns/100ps

module mvu_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic [mvu_pkg::BBANKA-1:0]   wbaseaddr,
    input  logic [mvu_pkg::BBANKA-1:0]   ibaseaddr,
    input  logic [mvu_pkg::BBANKA-1:0]   wstride,
    input  logic [mvu_pkg::BBANKA-1:0]   istride,
    input  logic [mvu_pkg::BPREC-1:0]    wprecision,
    input  logic [mvu_pkg::BPREC-1:0]    iprecision,
    input  logic [mvu_pkg::BPREC-1:0]    oprecision,
    input  logic [mvu_pkg::BQMSBIDX-1:0] quant_msbidx,
    input  logic                         wrw_en,      // Weight bank write
    input  logic [mvu_pkg::BBANKA-1:0]   wrw_addr,
    input  logic [mvu_pkg::N_LANES-1:0]  wrw_word,
    input  logic                         wrc_en,      // Data bank write request
    input  logic [mvu_pkg::BBANKA-1:0]   wrc_addr,
    input  logic [mvu_pkg::N_LANES-1:0]  wrc_word,
    output logic                         wrc_grnt,
    output logic                         done,
    output logic                         irq,
    output logic [mvu_pkg::BQOUT-1:0]    result
);
    import mvu_pkg::*;

    logic               job_start;    // AGU to VVP
    logic               busy;         // AGU to bank
    logic               rd_en;
    logic               rd_last;
    logic [BBANKA-1:0]  rd_waddr;
    logic [BBANKA-1:0]  rd_iaddr;
    logic [BSHIFT-1:0]  rd_shift;
    logic               op_valid;     // Bank to VVP
    logic               op_last;
    logic [N_LANES-1:0] op_wplane;
    logic [N_LANES-1:0] op_iplane;
    logic [BSHIFT-1:0]  op_shift;

    mvu_agu u_agu (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .done       (done),
        .wbaseaddr  (wbaseaddr),
        .ibaseaddr  (ibaseaddr),
        .wstride    (wstride),
        .istride    (istride),
        .wprecision (wprecision),
        .iprecision (iprecision),
        .job_start  (job_start),
        .busy       (busy),
        .rd_en      (rd_en),
        .rd_last    (rd_last),
        .rd_waddr   (rd_waddr),
        .rd_iaddr   (rd_iaddr),
        .rd_shift   (rd_shift)
    );

    mvu_bank u_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .busy      (busy),
        .wrw_en    (wrw_en),
        .wrw_addr  (wrw_addr),
        .wrw_word  (wrw_word),
        .wrc_en    (wrc_en),
        .wrc_addr  (wrc_addr),
        .wrc_word  (wrc_word),
        .rd_en     (rd_en),
        .rd_waddr  (rd_waddr),
        .rd_iaddr  (rd_iaddr),
        .rd_shift  (rd_shift),
        .rd_last   (rd_last),
        .wrc_grnt  (wrc_grnt),
        .op_valid  (op_valid),
        .op_wplane (op_wplane),
        .op_iplane (op_iplane),
        .op_shift  (op_shift),
        .op_last   (op_last)
    );

    mvu_vvp u_vvp (
        .clk          (clk),
        .rst_n        (rst_n),
        .job_start    (job_start),
        .oprecision   (oprecision),
        .quant_msbidx (quant_msbidx),
        .op_valid     (op_valid),
        .op_wplane    (op_wplane),
        .op_iplane    (op_iplane),
        .op_shift     (op_shift),
        .op_last      (op_last),
        .done         (done),
        .irq          (irq),
        .result       (result)
    );

endmodule

// ==== bench/tb_mvu.sv ====
`timescale 1ns/100ps

module tb_mvu;
    import mvu_pkg::*;

    localparam string GOLDEN_FILE = "bench/mvu_golden.txt";
    localparam int    TIMEOUT     = 64;         // Cycle limit of every wait loop
    localparam int    POST_CYCLES = 8;          // Idle cycles watched after each done

    logic                clk = 1'b0;
    logic                rst_n, start, wrw_en, wrc_en, wrc_grnt, done, irq;
    logic [BBANKA-1:0]   wbaseaddr, ibaseaddr, wstride, istride, wrw_addr, wrc_addr;
    logic [BPREC-1:0]    wprecision, iprecision, oprecision;
    logic [BQMSBIDX-1:0] quant_msbidx;
    logic [N_LANES-1:0]  wrw_word, wrc_word;
    logic [BQOUT-1:0]    result;

    logic [31:0]         gold [0:255];          // Variable length records, op word first
    logic                pend_valid;            // Data write to race with the next job
    logic [BBANKA-1:0]   pend_addr;
    logic [N_LANES-1:0]  pend_word;
    logic                irq_exp;
    int                  jobs, value_errs, fail_errs;

    mvu_top dut (.*);

    always #4 clk = ~clk;                       // 8 ns period

    task automatic check_result(input string name, input logic [BQOUT-1:0] exp,
                                input logic [BQOUT-1:0] act);
        if (act !== exp) begin
            value_errs++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errs++;
            $display("[ERROR] %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic write_weight(input logic [BBANKA-1:0] addr, input logic [N_LANES-1:0] word);
        wrw_en   = 1'b1;
        wrw_addr = addr;
        wrw_word = word;
        @(posedge clk);                         // No handshake, written on this edge
        #1 wrw_en = 1'b0;
    endtask

    task automatic write_data(input logic [BBANKA-1:0] addr, input logic [N_LANES-1:0] word);
        int waits;
        wrc_en   = 1'b1;
        wrc_addr = addr;
        wrc_word = word;
        waits    = 0;
        #1;                                     // Grant is combinational
        check_flag("grant_idle", 1'b1, wrc_grnt);
        while (!wrc_grnt && waits < TIMEOUT) begin
            @(posedge clk);
            #2;
            waits++;
        end
        if (!wrc_grnt) begin
            fail_errs++;
            $display("Timeout: data write to %h was never granted", addr);
        end
        @(posedge clk);                         // Granted write lands here
        #1 wrc_en = 1'b0;
    endtask

    // Job record at gold[p], expected result in the last field
    task automatic run_job(input logic spurious, input int p);
        int    nops;
        int    cycles;
        logic  at_done;
        string tag;
        nops = (gold[p+5] + 1) * (gold[p+6] + 1);
        tag  = $sformatf("job%0d", jobs);
        check_flag({tag, "_irq_before"}, irq_exp, irq);
        wbaseaddr    = BBANKA'(gold[p+1]);
        ibaseaddr    = BBANKA'(gold[p+2]);
        wstride      = BBANKA'(gold[p+3]);
        istride      = BBANKA'(gold[p+4]);
        wprecision   = BPREC'(gold[p+5]);
        iprecision   = BPREC'(gold[p+6]);
        oprecision   = BPREC'(gold[p+7]);
        quant_msbidx = BQMSBIDX'(gold[p+8]);
        start        = 1'b1;
        @(posedge clk);                         // Accepting edge
        #1 start = 1'b0;
        if (pend_valid) begin
            wrc_en   = 1'b1;                    // Request while busy, held until granted
            wrc_addr = pend_addr;
            wrc_word = pend_word;
        end
        if (spurious) begin
            wprecision   = '0;                  // Would change the result if latched
            oprecision   = '0;
            quant_msbidx = '0;
            wbaseaddr    = '0;
        end
        cycles = 0;
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            at_done = (cycles == nops + 5);     // Only cycle where done is due
            start   = spurious && (cycles == 3);  // Ignored start pulse mid-job
            check_flag({tag, "_done_timing"}, at_done, done);
            check_flag({tag, "_irq_in_job"}, at_done, irq);
            if (pend_valid) begin
                check_flag({tag, "_grant_busy"}, at_done, wrc_grnt);   // Busy drops with done
            end
        end
        if (!done) begin
            fail_errs++;
            $display("Timeout: %s never raised done", tag);
        end
        check_result({tag, "_result"}, BQOUT'(gold[p+9]), result);
        for (int i = 0; i < POST_CYCLES; i++) begin
            @(posedge clk);                     // First edge also takes a pending write
            #1 wrc_en = 1'b0;
            check_flag({tag, "_single_done"}, 1'b0, done);
            check_flag({tag, "_irq_held"}, 1'b1, irq);
        end
        pend_valid = 1'b0;
        irq_exp    = 1'b1;
        jobs++;
    endtask

    initial begin
        int p;
        rst_n        = 1'b0;
        start        = 1'b0;
        wbaseaddr    = '0;
        ibaseaddr    = '0;
        wstride      = '0;
        istride      = '0;
        wprecision   = '0;
        iprecision   = '0;
        oprecision   = '0;
        quant_msbidx = '0;
        wrw_en       = 1'b0;
        wrw_addr     = '0;
        wrw_word     = '0;
        wrc_en       = 1'b0;
        wrc_addr     = '0;
        wrc_word     = '0;
        pend_valid   = 1'b0;
        pend_addr    = '0;
        pend_word    = '0;
        irq_exp      = 1'b0;
        jobs         = 0;
        value_errs   = 0;
        fail_errs    = 0;
        $readmemh(GOLDEN_FILE, gold);
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        check_flag("reset_done", 1'b0, done);
        check_flag("reset_irq", 1'b0, irq);
        check_flag("reset_grant", 1'b0, wrc_grnt);
        check_result("reset_result", '0, result);
        p = 0;
        while (p < 240 && gold[p] != 0) begin
            case (gold[p])
                1: write_weight(BBANKA'(gold[p+1]), N_LANES'(gold[p+2]));
                2: write_data(BBANKA'(gold[p+1]), N_LANES'(gold[p+2]));
                3: run_job(1'b0, p);
                5: run_job(1'b1, p);
                4: begin
                    pend_valid = 1'b1;
                    pend_addr  = BBANKA'(gold[p+1]);
                    pend_word  = N_LANES'(gold[p+2]);
                end
                default: begin
                    fail_errs++;
                    $display("Unknown record type %h at golden word %0d", gold[p], p);
                end
            endcase
            p += (gold[p] == 3 || gold[p] == 5) ? 10 : 3;
        end
        if (jobs == 0) begin
            fail_errs++;
            $display("No jobs were read from the golden file");
        end
        $display("Errors: %0d value mismatches, %0d other failures", value_errs, fail_errs);
        if (value_errs == 0 && fail_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== bench/mvu_golden.txt ====
// op 1 weight write, op 2 data write, op 4 data write raced with the next job: op addr word
// op 3 job, op 5 job with an ignored mid-job start, op 0 ends the file
// job fields: op wbase ibase wstride istride wprec iprec oprec qmsb expected
1 00 F0F3
2 00 FF31
1 01 8421
2 01 FFFF
1 10 00FF
1 12 0F0F
2 20 3333
2 23 5555
2 26 FF00
1 30 FFFF
1 31 0000
1 32 00FF
1 33 F000
2 08 000F
2 0C 00F0
2 10 0F00
2 14 F000
3 00 00 01 01 0 0 3 3 7
3 00 00 01 01 0 0 3 2 E
4 01 00FF
3 01 01 01 01 0 0 3 3 4
3 01 01 01 01 0 0 3 3 2
3 10 20 02 03 1 2 3 6 8
3 30 08 01 04 3 3 3 8 B
3 30 08 01 04 3 3 3 7 F
3 30 08 01 04 3 3 1 7 3
5 30 08 01 04 3 3 3 8 B
0

// ==== flist.f ====
hw/mvu_pkg.sv
hw/mvu_agu.sv
hw/mvu_bank.sv
hw/mvu_vvp.sv
hw/mvu_top.sv
bench/tb_mvu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the MVU lane with its testbench and run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_mvu -o sim_mvu \
    && ./obj_dir/sim_mvu | tee /dev/stderr | grep -qF '*** PASSED ***' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
